//--- files.f
dcmp_pkg.sv
dcmp_classify.sv
dcmp_cond_text.sv
dcmp_dp_text.sv
dcmp_hex_text.sv
dcmp_line_build.sv
dcmp_top.sv
tb_dcmp.sv

//--- Makefile
# Verilator build and run of the disassembler testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_dcmp, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module tb_dcmp \
		-Mdir obj_dir -o tb_dcmp
	./obj_dir/tb_dcmp > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

//--- tb_dcmp.sv
// ------------------------------------------------
// Testbench for the two-stage disassembler
// Random words checked against a text model, with
// ordering and latency checks on every output
// ------------------------------------------------
`default_nettype none

module tb_dcmp import dcmp_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int N_IDLE = 10;
        localparam int N_DP   = 80;
        localparam int N_BR   = 60;
        localparam int N_RAND = 200;
        localparam int N_MIX  = 200;
        // Mixed test spends up to two cycles per word
        localparam int unsigned STIM_CYCLES = N_IDLE + N_DP + N_BR + N_RAND + 2 * N_MIX;
        localparam int unsigned CYCLE_LIMIT = 3 * STIM_CYCLES + 100;

        typedef struct {
                instr_t      word;
                insn_class_t cls;
                mnem_t       mnem;
                ops_t        ops;
                int unsigned due;      // Cycle the output belongs in
        } expected_t;

        logic        i_clk;
        logic        i_rst_n;
        logic        i_valid;
        instr_t      i_instruction;
        logic        o_valid;
        insn_class_t o_class;
        mnem_t       o_mnem;
        ops_t        o_ops;

        expected_t   exp_q[$];
        int unsigned cyc = 0;
        int          err_count = 0;
        int          checked = 0;
        int          tests_run = 0;
        int          tests_bad = 0;

        dcmp_top uut (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_valid       (i_valid),
                .i_instruction (i_instruction),
                .o_valid       (o_valid),
                .o_class       (o_class),
                .o_mnem        (o_mnem),
                .o_ops         (o_ops)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #5 i_clk = ~i_clk;
        end

        // Watchdog
        always @(posedge i_clk)
        begin
                cyc <= cyc + 1;
                if (cyc >= CYCLE_LIMIT)
                begin
                        $display("Run stopped after %0d cycles without finishing", cyc);
                        $display("Test failed");
                        $finish;
                end
        end

        // ------------------------------------------------
        // Reference model
        // ------------------------------------------------
        function automatic insn_class_t ref_class(instr_t w);
                if (w[27:24] == 4'b1111)
                        return CLS_SWI;
                if (w[27:25] == 3'b101)
                        return CLS_BRANCH;
                if (w[27:25] == 3'b001)
                        return CLS_DP_IMM;
                if (w[27:25] == 3'b000 && w[11:4] == 8'h00)
                        return CLS_DP_REG;
                return CLS_UNKNOWN;
        endfunction

        function automatic string cond_name(logic [3:0] c);
                string t = "EQNECSCCMIPLVSVCHILSGELTGTLEALNV";
                int    k;
                k = 2 * int'(c);
                return t.substr(k, k + 1);
        endfunction

        function automatic string op_name(logic [3:0] op);
                string t = "ANDEORSUBRSBADDADCSBCRSCTSTTEQCMPCMNORRMOVBICMVN";
                int    k;
                k = 3 * int'(op);
                return t.substr(k, k + 2);
        endfunction

        function automatic string reg_label(logic [3:0] r);
                string s;
                if (r < 4'd13)
                        s = $sformatf("R%0d", r);
                else if (r == 4'd13)
                        s = "SP";
                else if (r == 4'd14)
                        s = "LR";
                else
                        s = "PC";
                if (s.len() < REG_CHARS)
                        s = {s, " "};
                return s;
        endfunction

        // Last n hex digits of v, upper case
        function automatic string hex_digits(instr_t v, int n);
                string s;
                s = $sformatf("%08h", v);
                s = s.toupper();
                return s.substr(8 - n, 7);
        endfunction

        function automatic mnem_t pad_mnem(string s);
                mnem_t r;
                for (int i = 0; i < MNEM_CHARS; i++)
                        r[MNEM_CHARS-1-i] = (i < s.len()) ? s[i] : CHAR_SPACE;
                return r;
        endfunction

        function automatic ops_t pad_ops(string s);
                ops_t r;
                for (int i = 0; i < OPS_CHARS; i++)
                        r[OPS_CHARS-1-i] = (i < s.len()) ? s[i] : CHAR_SPACE;
                return r;
        endfunction

        function automatic expected_t ref_line(instr_t w);
                expected_t e;
                string     cond;
                string     rd;
                string     rn;
                string     mnem;
                string     ops;
                e.word = w;
                e.cls  = ref_class(w);
                e.due  = 0;
                cond   = cond_name(w[31:28]);
                rd     = reg_label(w[15:12]);
                rn     = reg_label(w[19:16]);
                case (e.cls)
                CLS_DP_IMM:
                begin
                        mnem = {op_name(w[24:21]), cond};
                        ops  = {rd, ",", rn, ",#", hex_digits({20'h0, w[11:0]}, 3)};
                end
                CLS_DP_REG:
                begin
                        mnem = {op_name(w[24:21]), cond};
                        ops  = {rd, ",", rn, ",", reg_label(w[3:0])};
                end
                CLS_BRANCH:
                begin
                        if (w[24])
                                mnem = {"BL", cond};
                        else
                                mnem = {"B", cond};
                        ops  = hex_digits({8'h0, w[23:0]}, 6);
                end
                CLS_SWI:
                begin
                        mnem = {"SWI", cond};
                        ops  = hex_digits({8'h0, w[23:0]}, 6);
                end
                default:
                begin
                        mnem = "UND";
                        ops  = hex_digits(w, 8);
                end
                endcase
                e.mnem = pad_mnem(mnem);
                e.ops  = pad_ops(ops);
                return e;
        endfunction

        // Kinds 0 to 3 DP imm, DP reg, branch, SWI; 4 raw; 5 shifted register form
        function automatic instr_t random_word(int kind);
                instr_t w;
                w = $urandom();
                case (kind)
                0: w[27:25] = 3'b001;
                1:
                begin
                        w[27:25] = 3'b000;
                        w[11:4]  = 8'h00;
                end
                2: w[27:25] = 3'b101;
                3: w[27:24] = 4'b1111;
                5:
                begin
                        w[27:25] = 3'b000;
                        w[11:4]  = 8'($urandom_range(1, 255));
                end
                default: ;
                endcase
                return w;
        endfunction

        // ------------------------------------------------
        // Compare tasks
        // ------------------------------------------------
        task automatic compare_class(insn_class_t got, insn_class_t want, instr_t w);
                if (got !== want)
                begin
                        $display("error at %0t ns: class of %08h is %s, expected %s",
                                 $time, w, got.name(), want.name());
                        err_count++;
                end
        endtask

        task automatic compare_mnem(mnem_t got, mnem_t want, instr_t w);
                if (got !== want)
                begin
                        $display("error at %0t ns: mnemonic of %08h is \"%s\", expected \"%s\"",
                                 $time, w, got, want);
                        err_count++;
                end
        endtask

        task automatic compare_ops(ops_t got, ops_t want, instr_t w);
                if (got !== want)
                begin
                        $display("error at %0t ns: operands of %08h are \"%s\", expected \"%s\"",
                                 $time, w, got, want);
                        err_count++;
                end
        endtask

        // Outputs are stable at the falling edge
        task automatic check_outputs();
                expected_t e;
                if (o_valid)
                begin
                        if (exp_q.size() == 0)
                        begin
                                $display("Output valid at %0t ns with no word waiting",
                                         $time);
                                err_count++;
                        end
                        else
                        begin
                                e = exp_q.pop_front();
                                if (e.due != cyc)
                                begin
                                        $display("error at %0t ns: %08h in cycle %0d, due %0d",
                                                 $time, e.word, cyc, e.due);
                                        err_count++;
                                end
                                compare_class(o_class, e.cls, e.word);
                                compare_mnem(o_mnem, e.mnem, e.word);
                                compare_ops(o_ops, e.ops, e.word);
                                checked++;
                        end
                end
                else if (exp_q.size() != 0 && exp_q[0].due <= cyc)
                begin
                        e = exp_q.pop_front();
                        $display("No output for word %08h by %0t ns", e.word, $time);
                        err_count++;
                end
        endtask

        task automatic step(logic v, instr_t w);
                expected_t e;
                @(negedge i_clk);
                check_outputs();
                i_valid       = v;
                i_instruction = w;
                if (v)
                begin
                        e     = ref_line(w);
                        e.due = cyc + 2;
                        exp_q.push_back(e);
                end
        endtask

        task automatic end_test(string name, int start_err);
                int n;
                while (exp_q.size() != 0)
                        step(1'b0, $urandom());
                repeat (3)
                        step(1'b0, $urandom());   // No stray outputs
                n = err_count - start_err;
                tests_run++;
                if (n != 0)
                        tests_bad++;
                $display("%-14s finished with %0d errors", name, n);
        endtask

        // ------------------------------------------------
        // Test sequence
        // ------------------------------------------------
        initial
        begin
                int mark;
                void'($urandom(32'hc19d_cf12));
                i_rst_n       = 1'b0;
                i_valid       = 1'b0;
                i_instruction = '0;
                repeat (3)
                        @(negedge i_clk);
                i_rst_n = 1'b1;

                mark = err_count;
                repeat (N_IDLE)
                        step(1'b0, $urandom());
                end_test("reset_idle", mark);

                mark = err_count;
                for (int k = 0; k < N_DP; k++)
                        step(1'b1, random_word(k % 2));
                end_test("dp_random", mark);

                mark = err_count;
                for (int k = 0; k < N_BR; k++)
                        step(1'b1, random_word(2 + k % 2));
                end_test("branch_swi", mark);

                mark = err_count;
                for (int k = 0; k < N_RAND; k++)
                        step(1'b1, random_word(($urandom_range(0, 3) == 0) ? 5 : 4));
                end_test("unconstrained", mark);

                mark = err_count;
                for (int k = 0; k < N_MIX; k++)
                begin
                        if ($urandom_range(0, 3) == 0)
                                step(1'b0, $urandom());
                        step(1'b1, random_word(int'($urandom_range(0, 5))));
                end
                end_test("back_to_back", mark);

                $display("%0d tests, %0d with errors, %0d outputs checked, %0d errors",
                         tests_run, tests_bad, checked, err_count);
                if (err_count == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

`default_nettype wire

//--- dcmp_top.sv
// ------------------------------------------------
// Two-stage instruction disassembler top level
// ------------------------------------------------
`default_nettype none

module dcmp_top import dcmp_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_rst_n,
        input  logic        i_valid,
        input  instr_t      i_instruction,
        output logic        o_valid,
        output insn_class_t o_class,
        output mnem_t       o_mnem,
        output ops_t        o_ops
);

        logic        s1_valid;
        instr_t      s1_instr;
        insn_class_t s1_class;
        char_t [1:0] suffix;
        char_t [2:0] opcode;
        char_t [2:0] hex3;
        char_t [5:0] hex6;
        char_t [7:0] hex8;
        ops_t        reg_ops;
        ops_t        imm_ops;

        dcmp_classify u_classify (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_valid       (i_valid),
                .i_instruction (i_instruction),
                .o_valid       (s1_valid),
                .o_instr       (s1_instr),
                .o_class       (s1_class)
        );

        // ------------------------------------------------
        // Text lookups on the stage-one word
        // ------------------------------------------------
        dcmp_cond_text u_cond (
                .i_cond   (s1_instr[31:28]),
                .o_suffix (suffix)
        );

        dcmp_hex_text #(.DIGITS(3)) u_hex3 (.i_value(s1_instr[11:0]), .o_text(hex3));
        dcmp_hex_text #(.DIGITS(6)) u_hex6 (.i_value(s1_instr[23:0]), .o_text(hex6));
        dcmp_hex_text #(.DIGITS(8)) u_hex8 (.i_value(s1_instr),       .o_text(hex8));

        dcmp_dp_text u_dp (
                .i_instr   (s1_instr),
                .i_imm_hex (hex3),
                .o_opcode  (opcode),
                .o_reg_ops (reg_ops),
                .o_imm_ops (imm_ops)
        );

        dcmp_line_build u_line (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_valid   (s1_valid),
                .i_class   (s1_class),
                .i_instr   (s1_instr),
                .i_suffix  (suffix),
                .i_opcode  (opcode),
                .i_reg_ops (reg_ops),
                .i_imm_ops (imm_ops),
                .i_hex6    (hex6),
                .i_hex8    (hex8),
                .o_valid   (o_valid),
                .o_class   (o_class),
                .o_mnem    (o_mnem),
                .o_ops     (o_ops)
        );

endmodule

`default_nettype wire

//--- dcmp_line_build.sv
// ------------------------------------------------
// Stage two of the disassembler
// Picks and pads the mnemonic and operand fields
// by class, then registers them
// ------------------------------------------------
`default_nettype none

module dcmp_line_build import dcmp_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_rst_n,
        input  logic        i_valid,
        input  insn_class_t i_class,
        input  instr_t      i_instr,
        input  char_t [1:0] i_suffix,
        input  char_t [2:0] i_opcode,
        input  ops_t        i_reg_ops,
        input  ops_t        i_imm_ops,
        input  char_t [5:0] i_hex6,
        input  char_t [7:0] i_hex8,
        output logic        o_valid,
        output insn_class_t o_class,
        output mnem_t       o_mnem,
        output ops_t        o_ops
);

        mnem_t mnem_next;
        ops_t  ops_next;

        // ------------------------------------------------
        // Field selection
        // ------------------------------------------------
        always_comb
        begin
                case (i_class)
                CLS_DP_IMM:
                begin
                        mnem_next = {i_opcode, i_suffix, {3{CHAR_SPACE}}};
                        ops_next  = i_imm_ops;
                end
                CLS_DP_REG:
                begin
                        mnem_next = {i_opcode, i_suffix, {3{CHAR_SPACE}}};
                        ops_next  = i_reg_ops;
                end
                CLS_BRANCH:
                begin
                        if (i_instr[24])    // Link bit
                                mnem_next = {"BL", i_suffix, {4{CHAR_SPACE}}};
                        else
                                mnem_next = {"B", i_suffix, {5{CHAR_SPACE}}};
                        ops_next = {i_hex6, {10{CHAR_SPACE}}};
                end
                CLS_SWI:
                begin
                        mnem_next = {"SWI", i_suffix, {3{CHAR_SPACE}}};
                        ops_next  = {i_hex6, {10{CHAR_SPACE}}};
                end
                default:
                begin
                        mnem_next = {"UND", {5{CHAR_SPACE}}};
                        ops_next  = {i_hex8, {8{CHAR_SPACE}}};   // Raw word
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        o_valid <= 1'b0;
                        o_class <= CLS_UNKNOWN;
                        o_mnem  <= {MNEM_CHARS{CHAR_SPACE}};
                        o_ops   <= {OPS_CHARS{CHAR_SPACE}};
                end
                else
                begin
                        o_valid <= i_valid;
                        if (i_valid)
                        begin
                                o_class <= i_class;
                                o_mnem  <= mnem_next;
                                o_ops   <= ops_next;
                        end
                end
        end

        // Stage one must also come out of reset idle
        a_idle_after_reset : assert property (@(posedge i_clk)
                $rose(i_rst_n) |=> !o_valid);

endmodule

`default_nettype wire

//--- dcmp_hex_text.sv
// ------------------------------------------------
// Field to upper-case hex characters
// Top nibble lands in the first character
// ------------------------------------------------
`default_nettype none

module dcmp_hex_text import dcmp_pkg::*;
#(
        parameter int DIGITS = 8
)
(
        input  logic [4*DIGITS-1:0] i_value,
        output char_t [DIGITS-1:0]  o_text
);

        for (genvar k = 0; k < DIGITS; k++)
        begin : g_digit
                logic [3:0] nib;

                assign nib = i_value[4*k+3 -: 4];

                // '0' is 0x30, 'A' minus ten is 0x37
                assign o_text[k] = (nib < 4'd10) ? (8'h30 + {4'h0, nib})
                                                 : (8'h37 + {4'h0, nib});
        end

endmodule

`default_nettype wire

//--- dcmp_dp_text.sv
// ------------------------------------------------
// Data-processing text
// Opcode name plus register and immediate operand
// layouts for the stage-one word
// ------------------------------------------------
`default_nettype none

module dcmp_dp_text import dcmp_pkg::*;
(
        input  instr_t      i_instr,
        input  char_t [2:0] i_imm_hex,
        output char_t [2:0] o_opcode,
        output ops_t        o_reg_ops,
        output ops_t        o_imm_ops
);

        reg_text_t rd_text;
        reg_text_t rn_text;
        reg_text_t rm_text;

        // Register names, space padded to three characters
        function automatic reg_text_t reg_name(input logic [3:0] r);
                case (r)
                4'd0:    reg_name = "R0 ";
                4'd1:    reg_name = "R1 ";
                4'd2:    reg_name = "R2 ";
                4'd3:    reg_name = "R3 ";
                4'd4:    reg_name = "R4 ";
                4'd5:    reg_name = "R5 ";
                4'd6:    reg_name = "R6 ";
                4'd7:    reg_name = "R7 ";
                4'd8:    reg_name = "R8 ";
                4'd9:    reg_name = "R9 ";
                4'd10:   reg_name = "R10";
                4'd11:   reg_name = "R11";
                4'd12:   reg_name = "R12";
                4'd13:   reg_name = "SP ";
                4'd14:   reg_name = "LR ";
                default: reg_name = "PC ";
                endcase
        endfunction

        // ------------------------------------------------
        // Opcode from bits 24:21
        // ------------------------------------------------
        always_comb
        begin
                case (i_instr[24:21])
                4'd0:    o_opcode = "AND";
                4'd1:    o_opcode = "EOR";
                4'd2:    o_opcode = "SUB";
                4'd3:    o_opcode = "RSB";
                4'd4:    o_opcode = "ADD";
                4'd5:    o_opcode = "ADC";
                4'd6:    o_opcode = "SBC";
                4'd7:    o_opcode = "RSC";
                4'd8:    o_opcode = "TST";
                4'd9:    o_opcode = "TEQ";
                4'd10:   o_opcode = "CMP";
                4'd11:   o_opcode = "CMN";
                4'd12:   o_opcode = "ORR";
                4'd13:   o_opcode = "MOV";
                4'd14:   o_opcode = "BIC";
                default: o_opcode = "MVN";
                endcase
        end

        assign rd_text = reg_name(i_instr[15:12]);
        assign rn_text = reg_name(i_instr[19:16]);
        assign rm_text = reg_name(i_instr[3:0]);

        // Rd,Rn,Rm then five pad characters
        assign o_reg_ops = {rd_text, CHAR_COMMA, rn_text, CHAR_COMMA, rm_text,
                            {5{CHAR_SPACE}}};

        // Rd,Rn,#hhh then four pad characters
        assign o_imm_ops = {rd_text, CHAR_COMMA, rn_text, CHAR_COMMA, "#", i_imm_hex,
                            {4{CHAR_SPACE}}};

endmodule

`default_nettype wire

//--- dcmp_cond_text.sv
// ------------------------------------------------
// Condition field to two-character suffix
// ------------------------------------------------
`default_nettype none

module dcmp_cond_text import dcmp_pkg::*;
(
        input  logic [3:0]  i_cond,
        output char_t [1:0] o_suffix
);

        always_comb
        begin
                case (i_cond)
                4'd0:    o_suffix = "EQ";
                4'd1:    o_suffix = "NE";
                4'd2:    o_suffix = "CS";
                4'd3:    o_suffix = "CC";
                4'd4:    o_suffix = "MI";
                4'd5:    o_suffix = "PL";
                4'd6:    o_suffix = "VS";
                4'd7:    o_suffix = "VC";
                4'd8:    o_suffix = "HI";
                4'd9:    o_suffix = "LS";
                4'd10:   o_suffix = "GE";
                4'd11:   o_suffix = "LT";
                4'd12:   o_suffix = "GT";
                4'd13:   o_suffix = "LE";
                COND_AL: o_suffix = "AL";
                default: o_suffix = "NV";   // Value 15
                endcase
        end

endmodule

`default_nettype wire

//--- dcmp_classify.sv
// ------------------------------------------------
// Stage one of the disassembler
// Classifies the word and registers word, class
// and strobe
// ------------------------------------------------
`default_nettype none

module dcmp_classify import dcmp_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_rst_n,
        input  logic        i_valid,
        input  instr_t      i_instruction,
        output logic        o_valid,
        output instr_t      o_instr,
        output insn_class_t o_class
);

        insn_class_t cls_next;

        // First match wins
        always_comb
        begin
                if (i_instruction[27:24] == GRP_SWI)
                        cls_next = CLS_SWI;
                else if (i_instruction[27:25] == GRP_BRANCH)
                        cls_next = CLS_BRANCH;
                else if (i_instruction[27:25] == GRP_DP_IMM)
                        cls_next = CLS_DP_IMM;
                else if (i_instruction[27:25] == GRP_DP_REG && i_instruction[11:4] == 8'h00)
                        cls_next = CLS_DP_REG;      // Unshifted register operand only
                else
                        cls_next = CLS_UNKNOWN;
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        o_valid <= 1'b0;
                        o_class <= CLS_UNKNOWN;
                end
                else
                begin
                        o_valid <= i_valid;
                        if (i_valid)
                                o_class <= cls_next;
                end
        end

        // Word held until the next strobe
        always_ff @(posedge i_clk)
        begin
                if (i_valid)
                        o_instr <= i_instruction;
        end

        a_class_legal : assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_valid |-> o_class inside {CLS_DP_IMM, CLS_DP_REG, CLS_BRANCH,
                                            CLS_SWI, CLS_UNKNOWN});

endmodule

`default_nettype wire

//--- dcmp_pkg.sv
// ------------------------------------------------
// Disassembler shared definitions
// Widths, text field types, instruction classes
// and the opcode-group and condition constants
// ------------------------------------------------
`default_nettype none

package dcmp_pkg;

        // Widths and counts
        localparam int INSTR_W    = 32;
        localparam int CHAR_W     = 8;
        localparam int MNEM_CHARS = 8;
        localparam int OPS_CHARS  = 16;
        localparam int REG_CHARS  = 3;

        // ------------------------------------------------
        // Text types, first character in the top byte
        // ------------------------------------------------
        typedef logic [INSTR_W-1:0] instr_t;
        typedef logic [CHAR_W-1:0]  char_t;

        typedef char_t [MNEM_CHARS-1:0] mnem_t;
        typedef char_t [OPS_CHARS-1:0]  ops_t;
        typedef char_t [REG_CHARS-1:0]  reg_text_t;

        typedef enum logic [2:0] {
                CLS_DP_IMM  = 3'd0,
                CLS_DP_REG  = 3'd1,
                CLS_BRANCH  = 3'd2,
                CLS_SWI     = 3'd3,
                CLS_UNKNOWN = 3'd4
        } insn_class_t;

        // Characters
        localparam char_t CHAR_SPACE = 8'h20;
        localparam char_t CHAR_COMMA = 8'h2C;

        // ------------------------------------------------
        // Opcode group patterns
        // ------------------------------------------------
        localparam logic [3:0] GRP_SWI    = 4'b1111;   // Bits 27:24
        localparam logic [2:0] GRP_BRANCH = 3'b101;    // Bits 27:25
        localparam logic [2:0] GRP_DP_IMM = 3'b001;
        localparam logic [2:0] GRP_DP_REG = 3'b000;

        // Condition field value for unconditional execution
        localparam logic [3:0] COND_AL = 4'd14;

endpackage

`default_nettype wire
